// ==== common/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

	// Table sizes
	localparam int BTB_ENTRIES = 16;	// Fully associative rows
	localparam int BHT_ENTRIES = 64;	// Bimodal counters

	// Index widths follow from the sizes
	localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
	localparam int BHT_IDX_W = $clog2(BHT_ENTRIES);

	// Address widths
	localparam int PC_W = 32;
	localparam int WORD_W = PC_W - 2;	// PC without the byte offset

	// Byte address as seen by fetch
	typedef logic [PC_W-1:0] pc_t;

	// Word address, used for BTB tags and stored targets
	typedef logic [WORD_W-1:0] word_addr_t;

	// BTB row number
	typedef logic [BTB_IDX_W-1:0] btb_idx_t;

	// Counter index, taken from PC[7:2]
	typedef logic [BHT_IDX_W-1:0] bht_idx_t;

	// Two-bit saturating counter
	typedef logic [1:0] ctr_t;

	// Counter encodings
	localparam ctr_t CTR_MIN = 2'b00;	// Strongly not-taken
	localparam ctr_t CTR_RESET = 2'b01;	// Weakly not-taken
	localparam ctr_t CTR_MAX = 2'b11;	// Strongly taken

	// Upper counter bit means predict taken
	localparam int CTR_TAKEN_BIT = 1;

endpackage

`default_nettype wire

// ==== btb/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btb (
	input wire clock,
	input wire reset,

	// Fetch side lookup
	input wire bp_pkg::pc_t lookup_pc,

	// Resolved branch from execute
	input wire update_valid,
	input wire update_taken,
	input wire bp_pkg::pc_t update_pc,
	input wire bp_pkg::pc_t update_target,

	// Lookup result, combinational from lookup_pc
	output logic hit,
	output bp_pkg::word_addr_t target
);

	// Row storage
	logic [bp_pkg::BTB_ENTRIES-1:0] valid;
	bp_pkg::word_addr_t tags [bp_pkg::BTB_ENTRIES];	// Full word address, no aliasing
	bp_pkg::word_addr_t targets [bp_pkg::BTB_ENTRIES];

	// Rows fill in order, so the count is also the next free row
	logic [bp_pkg::BTB_IDX_W:0] fill_count;
	bp_pkg::btb_idx_t oldest;	// Round-robin victim once full
	logic table_full;

	// CAM match lines
	logic [bp_pkg::BTB_ENTRIES-1:0] lookup_match;
	logic [bp_pkg::BTB_ENTRIES-1:0] update_match;

	// Update decode
	logic update_hit;
	bp_pkg::btb_idx_t update_row;	// Row that holds update_pc
	bp_pkg::btb_idx_t write_row;	// Row written this cycle
	logic write_en;

	// Search every row for both addresses in parallel
	always_comb begin
		for (int i = 0; i < bp_pkg::BTB_ENTRIES; i++) begin
			lookup_match[i] = valid[i] && (tags[i] == lookup_pc[31:2]);
			update_match[i] = valid[i] && (tags[i] == update_pc[31:2]);
		end
	end

	// Lookup result
	// At most one line is set, so an OR of the masked targets is enough
	assign hit = |lookup_match;

	always_comb begin
		target = '0;
		for (int i = 0; i < bp_pkg::BTB_ENTRIES; i++) begin
			if (lookup_match[i]) begin
				target = target | targets[i];
			end
		end
	end

	// Encode the update match into a row number
	always_comb begin
		update_hit = |update_match;
		update_row = '0;
		for (int i = 0; i < bp_pkg::BTB_ENTRIES; i++) begin
			if (update_match[i]) begin
				update_row = bp_pkg::btb_idx_t'(i);
			end
		end
	end

	assign table_full = (fill_count == (bp_pkg::BTB_IDX_W + 1)'(bp_pkg::BTB_ENTRIES));

	// Only taken branches touch the BTB
	assign write_en = update_valid && update_taken;

	// Hit rewrites in place, miss takes the next free row or the oldest one
	always_comb begin
		if (update_hit) begin
			write_row = update_row;
		end else if (table_full) begin
			write_row = oldest;
		end else begin
			write_row = fill_count[bp_pkg::BTB_IDX_W-1:0];
		end
	end

	// Valid bits, fill count and victim pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			fill_count <= '0;
			oldest <= '0;
		end else if (write_en) begin
			valid[write_row] <= 1'b1;
			if (!update_hit) begin	// New branch allocates a row
				if (table_full) begin
					oldest <= oldest + bp_pkg::btb_idx_t'(1);	// Next oldest row
				end else begin
					fill_count <= fill_count + (bp_pkg::BTB_IDX_W + 1)'(1);
				end
			end
		end
	end

	// Tag and target payload
	always_ff @(posedge clock) begin
		if (write_en) begin
			tags[write_row] <= update_pc[31:2];
			targets[write_row] <= update_target[31:2];	// Low two bits are dropped
		end
	end

	// Allocation must never create a second row for the same address
	a_single_match: assert property (@(posedge clock) disable iff (reset)
		$onehot0(lookup_match) && $onehot0(update_match))
		else $error("btb: more than one row matches an address");

endmodule

`default_nettype wire

// ==== verilog/direction_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module direction_table (
	input wire clock,
	input wire reset,

	// Fetch side lookup
	input wire bp_pkg::pc_t lookup_pc,

	// Resolved branch from execute
	input wire update_valid,
	input wire update_taken,
	input wire bp_pkg::pc_t update_pc,

	// Predicted direction, combinational from lookup_pc
	output logic taken
);

	// Bimodal counter array
	bp_pkg::ctr_t counters [bp_pkg::BHT_ENTRIES];

	bp_pkg::bht_idx_t lookup_idx;
	bp_pkg::bht_idx_t update_idx;
	bp_pkg::ctr_t update_ctr;	// Current value at update_idx
	bp_pkg::ctr_t next_ctr;	// Value after the saturating step

	// Index from PC[7:2], byte offset skipped
	assign lookup_idx = lookup_pc[bp_pkg::BHT_IDX_W+1:2];
	assign update_idx = update_pc[bp_pkg::BHT_IDX_W+1:2];

	// Upper bit decides the direction
	assign taken = counters[lookup_idx][bp_pkg::CTR_TAKEN_BIT];

	assign update_ctr = counters[update_idx];

	// Step by one toward the outcome, hold at either end
	always_comb begin
		next_ctr = update_ctr;
		if (update_taken) begin
			if (update_ctr != bp_pkg::CTR_MAX) begin
				next_ctr = update_ctr + bp_pkg::ctr_t'(1);
			end
		end else if (update_ctr != bp_pkg::CTR_MIN) begin
			next_ctr = update_ctr - bp_pkg::ctr_t'(1);
		end
	end

	// Counters are prediction state, so reset puts them all weakly not-taken
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < bp_pkg::BHT_ENTRIES; i++) begin
				counters[i] <= bp_pkg::CTR_RESET;
			end
		end else if (update_valid) begin
			counters[update_idx] <= next_ctr;	// Visible to lookups next cycle
		end
	end

	// Execute must report a resolved direction with every update
	a_update_known: assert property (@(posedge clock) disable iff (reset)
		update_valid |-> !$isunknown(update_taken))
		else $error("direction_table: update_taken unknown during update");

endmodule

`default_nettype wire

// ==== verilog/next_pc_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
	input wire clock,
	input wire reset,

	// Fetch request
	input wire fetch_valid,
	input wire bp_pkg::pc_t fetch_pc,

	// Table lookups for fetch_pc
	input wire btb_hit,
	input wire bp_pkg::word_addr_t btb_target,
	input wire dir_taken,

	// Registered prediction, one cycle after the fetch
	output logic pred_valid,
	output logic pred_taken,
	output bp_pkg::pc_t pred_pc
);

	logic take;	// Both tables agree on a taken branch
	bp_pkg::pc_t seq_pc;
	bp_pkg::pc_t next_pc;

	// A counter alone has no target, so the BTB must also hit
	assign take = btb_hit && dir_taken;
	assign seq_pc = fetch_pc + bp_pkg::pc_t'(4);	// Fall-through
	assign next_pc = take ? {btb_target, 2'b00} : seq_pc;

	// Control flags
	always_ff @(posedge clock) begin
		if (reset) begin
			pred_valid <= 1'b0;
			pred_taken <= 1'b0;
		end else begin
			pred_valid <= fetch_valid;
			pred_taken <= fetch_valid && take;	// Low on idle cycles
		end
	end

	// Predicted address, only loaded on a fetch
	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			pred_pc <= next_pc;
		end
	end

	// Fetch addresses are word aligned, and so are the stored targets
	a_pred_aligned: assert property (@(posedge clock) disable iff (reset)
		pred_valid |-> (pred_pc[1:0] == 2'b00))
		else $error("next_pc_select: unaligned pred_pc %h", pred_pc);

endmodule

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
	input wire clock,
	input wire reset,

	// Fetch
	input wire fetch_valid,
	input wire bp_pkg::pc_t fetch_pc,

	// Execute update
	input wire update_valid,
	input wire bp_pkg::pc_t update_pc,
	input wire update_taken,
	input wire bp_pkg::pc_t update_target,

	// Prediction
	output logic pred_valid,
	output logic pred_taken,
	output bp_pkg::pc_t pred_pc
);

	// Lookup results toward the selector
	logic btb_hit;
	bp_pkg::word_addr_t btb_target;
	logic dir_taken;

	// Target store, both tables share the update strobe
	btb u_btb (
		.clock(clock),
		.reset(reset),
		.lookup_pc(fetch_pc),
		.update_valid(update_valid),
		.update_taken(update_taken),
		.update_pc(update_pc),
		.update_target(update_target),
		.hit(btb_hit),
		.target(btb_target)
	);

	// Direction counters
	direction_table u_direction_table (
		.clock(clock),
		.reset(reset),
		.lookup_pc(fetch_pc),
		.update_valid(update_valid),
		.update_taken(update_taken),
		.update_pc(update_pc),
		.taken(dir_taken)
	);

	// Merge and register
	next_pc_select u_next_pc_select (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.btb_hit(btb_hit),
		.btb_target(btb_target),
		.dir_taken(dir_taken),
		.pred_valid(pred_valid),
		.pred_taken(pred_taken),
		.pred_pc(pred_pc)
	);

endmodule

`default_nettype wire

// ==== bench/tb_branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

	localparam int RESET_CYCLES = 16;
	localparam int MARGIN_CYCLES = 20;

	// One table row: update part, fetch part, expected prediction one cycle later
	typedef struct packed {
		logic [3:0] group;
		logic upd_valid;
		bp_pkg::pc_t upd_pc;
		logic upd_taken;
		bp_pkg::pc_t upd_target;
		logic fetch_valid;
		bp_pkg::pc_t fetch_pc;
		logic exp_taken;
		bp_pkg::pc_t exp_pc;
	} row_t;

	logic clock;
	logic reset;
	logic fetch_valid;
	bp_pkg::pc_t fetch_pc;
	logic update_valid;
	bp_pkg::pc_t update_pc;
	logic update_taken;
	bp_pkg::pc_t update_target;
	logic pred_valid;
	logic pred_taken;
	bp_pkg::pc_t pred_pc;

	row_t rows[$];
	string group_names [6];
	int group_checks [6];
	int group_errors [6];
	int check_count = 0;
	int error_count = 0;
	int cur_group = 0;
	int cur_row = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;	// Replaced once the table is built

	branch_predictor DUT (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.update_valid(update_valid),
		.update_pc(update_pc),
		.update_taken(update_taken),
		.update_target(update_target),
		.pred_valid(pred_valid),
		.pred_taken(pred_taken),
		.pred_pc(pred_pc)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;	// 4 ns period
	end

	// Watchdog over the whole run
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout, run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic add_row(input int group, input logic uv, input bp_pkg::pc_t upc,
			input logic ut, input bp_pkg::pc_t utgt, input logic fv,
			input bp_pkg::pc_t fpc, input logic et, input bp_pkg::pc_t epc);
		row_t r;
		r = '{group[3:0], uv, upc, ut, utgt, fv, fpc, et, epc};
		rows.push_back(r);
	endtask

	task automatic note_result(input logic ok);
		check_count++;
		group_checks[cur_group]++;
		if (!ok) begin
			error_count++;
			group_errors[cur_group]++;
		end
	endtask

	task automatic check_taken(input logic actual, input logic expected);
		if (actual !== expected)
			$display("FAILED pred_taken row %0d: got %h, expected %h", cur_row, actual, expected);
		note_result(actual === expected);
	endtask

	task automatic check_pc(input bp_pkg::pc_t actual, input bp_pkg::pc_t expected);
		if (actual !== expected)
			$display("FAILED pred_pc row %0d: got %h, expected %h", cur_row, actual, expected);
		note_result(actual === expected);
	endtask

	// pred_valid must follow fetch_valid by one cycle
	task automatic check_valid(input logic expected);
		if (pred_valid !== expected) begin
			if (expected)
				$display("Row %0d: no prediction came back for a fetch", cur_row);
			else
				$display("Row %0d: a prediction showed up where none was due", cur_row);
		end
		note_result(pred_valid === expected);
	endtask

	task automatic drive_row(input row_t r);
		update_valid = r.upd_valid;
		update_pc = r.upd_pc;
		update_taken = r.upd_taken;
		update_target = r.upd_target;
		fetch_valid = r.fetch_valid;
		fetch_pc = r.fetch_pc;
	endtask

	initial begin
		reset = 1'b1;
		drive_row('0);	// All inputs idle
		fetch_valid = 1'b1;	// Reset must hold the prediction back
		group_names = '{"after reset", "training", "hysteresis", "target rewrite",
			"replacement", "same-cycle update"};

		// Columns: group, upd valid, upd pc, upd taken, upd target, fetch valid, fetch pc,
		// expected taken, expected pc
		add_row(0, 0, 0, 0, 0, 1, 32'h1000, 0, 32'h1004);	// Untrained, fall through
		add_row(0, 0, 0, 0, 0, 1, 32'h2008, 0, 32'h200c);
		add_row(1, 1, 32'h100, 1, 32'h800, 0, 0, 0, 0);	// Counter 1 to 2, BTB row 0
		add_row(1, 0, 0, 0, 0, 1, 32'h100, 1, 32'h800);
		add_row(2, 1, 32'h100, 1, 32'h800, 1, 32'h100, 1, 32'h800);	// Sees 2, goes to 3
		add_row(2, 1, 32'h100, 1, 32'h800, 1, 32'h100, 1, 32'h800);	// Saturated at 3
		add_row(2, 1, 32'h100, 0, 0, 0, 0, 0, 0);	// 3 to 2
		add_row(2, 0, 0, 0, 0, 1, 32'h100, 1, 32'h800);	// Still taken
		add_row(2, 1, 32'h100, 0, 0, 0, 0, 0, 0);	// 2 to 1
		add_row(2, 0, 0, 0, 0, 1, 32'h100, 0, 32'h104);
		add_row(3, 1, 32'h100, 1, 32'hc00, 0, 0, 0, 0);	// Hit, new target, counter back to 2
		add_row(3, 0, 0, 0, 0, 1, 32'h100, 1, 32'hc00);
		// Slots 1 to 17; the 16th evicts 0x100, the 17th evicts slot 1's branch
		for (int k = 1; k <= 17; k++)
			add_row(4, 1, 32'h4000 + k * 4, 1, 32'h8000 + k * 16, 0, 0, 0, 0);
		add_row(4, 0, 0, 0, 0, 1, 32'h4004, 0, 32'h4008);	// First one gone
		add_row(4, 0, 0, 0, 0, 1, 32'h4044, 1, 32'h8110);	// Seventeenth present
		add_row(4, 0, 0, 0, 0, 1, 32'h100, 0, 32'h104);	// Evicted as oldest
		add_row(4, 0, 0, 0, 0, 1, 32'h4008, 1, 32'h8020);	// Second one survives
		add_row(5, 1, 32'h5080, 1, 32'h9000, 1, 32'h5080, 0, 32'h5084);	// Old state seen
		add_row(5, 0, 0, 0, 0, 1, 32'h5080, 1, 32'h9000);
		cycle_limit = rows.size() + RESET_CYCLES + MARGIN_CYCLES;

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		cur_row = -1;
		check_valid(1'b0);	// Fetch held high during reset gives no prediction
		fetch_valid = 1'b0;
		reset = 1'b0;
		@(negedge clock);
		check_valid(1'b0);	// First cycle out of reset

		for (int i = 0; i <= rows.size(); i++) begin
			if (i > 0) begin
				@(negedge clock);	// Outputs settled after the rising edge
				cur_row = i - 1;
				cur_group = rows[i - 1].group;
				check_valid(rows[i - 1].fetch_valid);
				if (rows[i - 1].fetch_valid && pred_valid === 1'b1) begin
					check_taken(pred_taken, rows[i - 1].exp_taken);
					check_pc(pred_pc, rows[i - 1].exp_pc);
				end
				if (i == rows.size() || rows[i].group != rows[i - 1].group)
					$display("Test %0d %s: %0d checks, %0d errors", cur_group,
						group_names[cur_group], group_checks[cur_group],
						group_errors[cur_group]);
			end
			if (i < rows.size())
				drive_row(rows[i]);
			else
				drive_row('0);
		end

		$display("Totals: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
common/bp_pkg.sv
btb/btb.sv
verilog/direction_table.sv
verilog/next_pc_select.sv
verilog/branch_predictor.sv
bench/tb_branch_predictor.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - common/bp_pkg.sv
  - btb/btb.sv
  - verilog/direction_table.sv
  - verilog/next_pc_select.sv
  - verilog/branch_predictor.sv
  - target: test
    files:
      - bench/tb_branch_predictor.sv
